// ==== rtl/poker_settings.svh ====
`ifndef POKER_SETTINGS_SVH
`define POKER_SETTINGS_SVH

// hand shape
`define POKER_CARDS 5
`define POKER_RANK_W 4
`define POKER_SUIT_W 2

// category code width in the result register
`define POKER_CAT_W 4

// legal ranks, ace is 1 and king is 13
`define POKER_RANK_MIN 1
`define POKER_RANK_MAX 13

// apb bus widths
`define POKER_ADDR_W 8
`define POKER_DATA_W 32

// register map, card i sits at CARD0 + 4*i
`define POKER_CARD0_ADDR 8'h00
`define POKER_CTRL_ADDR 8'h14
`define POKER_RESULT_ADDR 8'h18

// bit positions inside ctrl and result
`define POKER_START_BIT 0
`define POKER_DONE_BIT 8

`endif

// ==== rtl/pokerPkg.sv ====
`default_nettype none
`include "poker_settings.svh"

package pokerPkg;

	typedef logic [`POKER_RANK_W-1:0] rankT;
	typedef logic [`POKER_SUIT_W-1:0] suitT;
	// bit r-1 is set when rank r is present
	typedef logic [`POKER_RANK_MAX-1:0] rankMaskT;
	typedef logic [`POKER_ADDR_W-1:0] apbAddrT;
	typedef logic [`POKER_DATA_W-1:0] apbDataT;

	// suit on top, rank below, same as the card register
	typedef struct packed {
		suitT suit;
		rankT rank;
	} cardT;

	typedef cardT [`POKER_CARDS-1:0] handT;

	// ordered so a larger code is a stronger hand
	typedef enum logic [`POKER_CAT_W-1:0] {
		catHighCard      = 4'd0,
		catOnePair       = 4'd1,
		catTwoPair       = 4'd2,
		catThree         = 4'd3,
		catStraight      = 4'd4,
		catFlush         = 4'd5,
		catFullHouse     = 4'd6,
		catFour          = 4'd7,
		catStraightFlush = 4'd8
	} handCatE;

	typedef struct packed {
		logic valid;
		handT hand;
	} evalReqT;

	typedef struct packed {
		logic       valid;
		// largest number of cards sharing one rank
		logic [2:0] maxCount;
		// distinct ranks seen two or more times
		logic [1:0] pairCount;
		logic       flush;
	} matchInfoT;

	typedef struct packed {
		logic    valid;
		handCatE cat;
	} evalResT;

	typedef struct packed {
		logic    psel;
		logic    penable;
		logic    pwrite;
		apbAddrT paddr;
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		apbDataT prdata;
		logic    pready;
		logic    pslverr;
	} apbRspT;

endpackage

`default_nettype wire

// ==== rtl/handRegs.sv ====
`default_nettype none
`include "poker_settings.svh"

module handRegs (
	input  logic              clk,
	input  logic              rst,
	input  pokerPkg::apbReqT  apbReq,
	output pokerPkg::apbRspT  apbRsp,
	output pokerPkg::evalReqT evalReq,
	input  pokerPkg::evalResT evalRes
);
	import pokerPkg::*;

	localparam int idxW = $clog2(`POKER_CARDS);

	// access phase qualifiers
	logic wrEn;
	logic rdEn;

	// address decode
	apbAddrT cardOff;
	logic [idxW-1:0] cardIdx;
	logic cardHit;
	logic ctrlHit;
	logic resHit;
	logic mapped;

	// register contents
	handT cards;
	handCatE resCat;
	logic done;
	logic startReq;
	logic evalValid;
	apbDataT rdData;

	// transfer happens in the access cycle, pready is tied high
	assign wrEn = apbReq.psel & apbReq.penable & apbReq.pwrite;
	assign rdEn = apbReq.psel & apbReq.penable & ~apbReq.pwrite;

	// card window is word aligned, one word per card
	assign cardOff = apbReq.paddr - apbAddrT'(`POKER_CARD0_ADDR);
	assign cardIdx = cardOff[2 +: idxW];
	assign cardHit = (cardOff[1:0] == 2'b00) && (cardOff < apbAddrT'(4 * `POKER_CARDS));
	assign ctrlHit = (apbReq.paddr == `POKER_CTRL_ADDR);
	assign resHit = (apbReq.paddr == `POKER_RESULT_ADDR);
	assign mapped = cardHit | ctrlHit | resHit;

	// start is a self clearing bit, nothing is stored for ctrl
	assign startReq = wrEn & ctrlHit & apbReq.pwdata[`POKER_START_BIT];

	// card registers, only the low 6 bits are kept
	always_ff @(posedge clk) begin
		if (rst) begin
			cards <= '0;
		end else if (wrEn && cardHit) begin
			cards[cardIdx] <= apbReq.pwdata[$bits(cardT)-1:0];
		end
	end

	// launch pulse, result latch and done flag
	always_ff @(posedge clk) begin
		if (rst) begin
			evalValid <= 1'b0;
			resCat <= catHighCard;
			done <= 1'b0;
		end else begin
			evalValid <= startReq;
			// results come back in order, the newest one overwrites
			if (evalRes.valid) begin
				resCat <= evalRes.cat;
			end
			// a new start wins over a result landing on the same edge
			if (startReq) begin
				done <= 1'b0;
			end else if (evalRes.valid) begin
				done <= 1'b1;
			end
		end
	end

	// hand comes straight from the card registers, valid for one cycle
	assign evalReq.valid = evalValid;
	assign evalReq.hand = cards;

	// read mux, ctrl and unmapped addresses read as zero
	always_comb begin
		rdData = '0;
		if (cardHit) begin
			rdData[$bits(cardT)-1:0] = cards[cardIdx];
		end else if (resHit) begin
			rdData[`POKER_CAT_W-1:0] = resCat;
			rdData[`POKER_DONE_BIT] = done;
		end
	end

	assign apbRsp.prdata = rdEn ? rdData : '0;
	assign apbRsp.pready = 1'b1;
	// error only while the access phase is on the bus
	assign apbRsp.pslverr = apbReq.psel & apbReq.penable & ~mapped;

endmodule

`default_nettype wire

// ==== rtl/cardMatcher.sv ====
`default_nettype none
`include "poker_settings.svh"

module cardMatcher (
	input  logic                clk,
	input  logic                rst,
	input  pokerPkg::evalReqT   evalReq,
	output pokerPkg::matchInfoT matchInfo
);
	import pokerPkg::*;

	localparam int numCards = `POKER_CARDS;

	// sameRank[i][j] is high when card i and card j share a rank
	logic [numCards-1:0] sameRank [numCards];
	logic [2:0] shareCnt [numCards];
	logic [2:0] maxCount;
	logic [1:0] pairCount;
	logic flush;

	// pairwise rank compare, the diagonal is always set
	always_comb begin
		for (int i = 0; i < numCards; i++) begin
			for (int j = 0; j < numCards; j++) begin
				sameRank[i][j] = (evalReq.hand[i].rank == evalReq.hand[j].rank);
			end
		end
	end

	// per card multiplicity, itself included
	always_comb begin
		for (int i = 0; i < numCards; i++) begin
			shareCnt[i] = '0;
			for (int j = 0; j < numCards; j++) begin
				shareCnt[i] = shareCnt[i] + 3'(sameRank[i][j]);
			end
		end
	end

	always_comb begin
		maxCount = '0;
		pairCount = '0;
		for (int i = 0; i < numCards; i++) begin
			if (shareCnt[i] > maxCount) begin
				maxCount = shareCnt[i];
			end
			// count a repeated rank only at its lowest card index
			if (shareCnt[i] >= 3'd2 && (sameRank[i] & ((numCards)'(1) << i) - 1'b1) == '0) begin
				pairCount = pairCount + 2'd1;
			end
		end
	end

	// flush means every suit equals the first card's suit
	always_comb begin
		flush = 1'b1;
		for (int i = 1; i < numCards; i++) begin
			if (evalReq.hand[i].suit != evalReq.hand[0].suit) begin
				flush = 1'b0;
			end
		end
	end

	// stage one register, payload loads every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			matchInfo.valid <= 1'b0;
		end else begin
			matchInfo.valid <= evalReq.valid;
		end
		matchInfo.maxCount <= maxCount;
		matchInfo.pairCount <= pairCount;
		matchInfo.flush <= flush;
	end

endmodule

`default_nettype wire

// ==== rtl/straightDetector.sv ====
`default_nettype none
`include "poker_settings.svh"

module straightDetector (
	input  logic              clk,
	input  logic              rst,
	input  pokerPkg::evalReqT evalReq,
	output logic              straight
);
	import pokerPkg::*;

	localparam int numCards = `POKER_CARDS;
	// ace low windows, 1-5 up to 9-13
	localparam int numLowWin = `POKER_RANK_MAX - numCards + 1;

	rankMaskT mask;
	// one extra window for ten through ace
	logic [numLowWin:0] winHit;

	// presence mask, out of range ranks are dropped here
	always_comb begin
		mask = '0;
		for (int i = 0; i < numCards; i++) begin
			if (evalReq.hand[i].rank >= rankT'(`POKER_RANK_MIN) &&
					evalReq.hand[i].rank <= rankT'(`POKER_RANK_MAX)) begin
				mask[evalReq.hand[i].rank - rankT'(`POKER_RANK_MIN)] = 1'b1;
			end
		end
	end

	// sliding window of five consecutive ranks
	always_comb begin
		for (int w = 0; w < numLowWin; w++) begin
			winHit[w] = &mask[w +: numCards];
		end
		// ten, jack, queen, king plus the ace counted high
		winHit[numLowWin] = (&mask[`POKER_RANK_MAX-1 -: numCards-1]) & mask[0];
	end

	// lines up with the cardMatcher register
	always_ff @(posedge clk) begin
		if (rst) begin
			straight <= 1'b0;
		end else begin
			straight <= |winHit;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/handClassifier.sv ====
`default_nettype none
`include "poker_settings.svh"

module handClassifier (
	input  logic                clk,
	input  logic                rst,
	input  pokerPkg::matchInfoT matchInfo,
	input  logic                straight,
	output pokerPkg::evalResT   evalRes
);
	import pokerPkg::*;

	handCatE cat;

	// strongest category first
	always_comb begin
		if (straight && matchInfo.flush) begin
			cat = catStraightFlush;
		end else if (matchInfo.maxCount >= 3'd4) begin
			// five of one rank also lands here
			cat = catFour;
		end else if (matchInfo.maxCount == 3'd3 && matchInfo.pairCount == 2'd2) begin
			cat = catFullHouse;
		end else if (matchInfo.flush) begin
			cat = catFlush;
		end else if (straight) begin
			cat = catStraight;
		end else if (matchInfo.maxCount == 3'd3) begin
			cat = catThree;
		end else if (matchInfo.pairCount == 2'd2) begin
			cat = catTwoPair;
		end else if (matchInfo.pairCount == 2'd1) begin
			cat = catOnePair;
		end else begin
			cat = catHighCard;
		end
	end

	// stage two register
	always_ff @(posedge clk) begin
		if (rst) begin
			evalRes.valid <= 1'b0;
		end else begin
			evalRes.valid <= matchInfo.valid;
		end
		evalRes.cat <= cat;
	end

endmodule

`default_nettype wire

// ==== rtl/pokerTop.sv ====
`default_nettype none
`include "poker_settings.svh"

module pokerTop (
	input  logic             clk,
	input  logic             rst,
	input  pokerPkg::apbReqT apbReq,
	output pokerPkg::apbRspT apbRsp
);
	import pokerPkg::*;

	// hand launched by a start write
	evalReqT evalReq;
	// stage one outputs
	matchInfoT matchInfo;
	logic straight;
	// stage two output back into the register block
	evalResT evalRes;

	// apb registers, launch and result capture
	handRegs u_handRegs (
		.clk     (clk),
		.rst     (rst),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.evalReq (evalReq),
		.evalRes (evalRes)
	);

	// multiplicity and flush
	cardMatcher u_cardMatcher (
		.clk       (clk),
		.rst       (rst),
		.evalReq   (evalReq),
		.matchInfo (matchInfo)
	);

	// straight runs in parallel with the matcher
	straightDetector u_straightDetector (
		.clk      (clk),
		.rst      (rst),
		.evalReq  (evalReq),
		.straight (straight)
	);

	handClassifier u_handClassifier (
		.clk       (clk),
		.rst       (rst),
		.matchInfo (matchInfo),
		.straight  (straight),
		.evalRes   (evalRes)
	);

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst
);
	localparam int halfPeriod = 5;
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// reset held over the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/pokerTb.sv ====
`default_nettype none
`include "poker_settings.svh"

module pokerTb;
	import pokerPkg::*;

	localparam int numCards = `POKER_CARDS;
	localparam int numRows = 19;
	// bounds for the wait loops
	localparam int readyLimit = 8;
	localparam int resetLimit = 20;
	localparam int pollLimit = 20;
	localparam apbDataT doneMask = apbDataT'(1) << `POKER_DONE_BIT;
	localparam apbDataT catMask = apbDataT'((1 << `POKER_CAT_W) - 1);
	localparam apbDataT cardMask = apbDataT'((1 << $bits(cardT)) - 1);
	localparam apbDataT startWord = apbDataT'(1) << `POKER_START_BIT;

	// ranks of cards 0 to 4, whether all suits match, expected category
	typedef struct packed {
		rankT [numCards-1:0] ranks;
		logic sameSuit;
		handCatE cat;
	} handRowT;

	logic clk;
	logic rst;
	apbReqT apbReq;
	apbRspT apbRsp;
	handRowT rows [numRows];
	// expected content of the card registers
	apbDataT cardShadow [numCards];
	// misaligned card slot, next to ctrl, past result, top of the map
	apbAddrT badAddr [4] = '{8'h02, 8'h16, 8'h1c, 8'hfc};

	clockGen u_clockGen (
		.clk (clk),
		.rst (rst)
	);

	pokerTop u_pokerTop (
		.clk    (clk),
		.rst    (rst),
		.apbReq (apbReq),
		.apbRsp (apbRsp)
	);

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkCat(input string name, input handCatE exp, input handCatE act);
		if (act !== exp) begin
			$display("** Error %s: expected %s (%0d), actual %s (%0d)",
				name, exp.name(), exp, act.name(), act);
			stopRun();
		end
	endtask

	task automatic checkData(input string name, input apbDataT exp, input apbDataT act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkErr(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected pslverr %b, actual %b", name, exp, act);
			stopRun();
		end
	endtask

	function automatic handRowT makeRow(input int r0, r1, r2, r3, r4,
			input logic sameSuit, input handCatE cat);
		handRowT row;
		row.ranks = {rankT'(r4), rankT'(r3), rankT'(r2), rankT'(r1), rankT'(r0)};
		row.sameSuit = sameSuit;
		row.cat = cat;
		return row;
	endfunction

	function automatic apbAddrT cardAddr(input int idx);
		return apbAddrT'(`POKER_CARD0_ADDR + 4 * idx);
	endfunction

	// filler suits are random but never line up into a flush
	function automatic handT buildHand(input handRowT row, input int idx);
		handT hand;
		logic allSame;
		allSame = 1'b1;
		for (int c = 0; c < numCards; c++) begin
			hand[c].rank = row.ranks[c];
			hand[c].suit = row.sameSuit ? suitT'(idx) : suitT'($urandom);
			if (hand[c].suit != hand[0].suit) begin
				allSame = 1'b0;
			end
		end
		if (!row.sameSuit && allSame) begin
			hand[numCards-1].suit = hand[0].suit + suitT'(1);
		end
		return hand;
	endfunction

	task automatic apbTransfer(input logic write, input apbAddrT addr, input apbDataT wdata,
			output apbDataT rdata, output logic err);
		int waitCnt;
		@(posedge clk);
		// setup phase
		apbReq.psel <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite <= write;
		apbReq.paddr <= addr;
		apbReq.pwdata <= wdata;
		@(posedge clk);
		apbReq.penable <= 1'b1;
		// access phase ends on the edge that sees pready
		waitCnt = 0;
		@(posedge clk);
		while (apbRsp.pready !== 1'b1) begin
			waitCnt++;
			if (waitCnt >= readyLimit) begin
				$display("pready never came for address %h", addr);
				stopRun();
			end
			@(posedge clk);
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		apbReq.psel <= 1'b0;
		apbReq.penable <= 1'b0;
	endtask

	task automatic apbWrite(input string name, input apbAddrT addr, input apbDataT data,
			input logic expErr);
		apbDataT rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		checkErr(name, expErr, err);
	endtask

	task automatic apbRead(input string name, input apbAddrT addr, output apbDataT data,
			input logic expErr);
		logic err;
		apbTransfer(1'b0, addr, '0, data, err);
		checkErr(name, expErr, err);
	endtask

	task automatic writeHand(input string name, input handT hand);
		for (int c = 0; c < numCards; c++) begin
			apbWrite(name, cardAddr(c), apbDataT'(hand[c]), 1'b0);
			cardShadow[c] = apbDataT'(hand[c]);
		end
	endtask

	task automatic waitDone(input string name, output apbDataT data);
		int polls;
		polls = 0;
		apbRead(name, `POKER_RESULT_ADDR, data, 1'b0);
		while (data[`POKER_DONE_BIT] !== 1'b1) begin
			polls++;
			if (polls >= pollLimit) begin
				$display("done never set for %s", name);
				stopRun();
			end
			apbRead(name, `POKER_RESULT_ADDR, data, 1'b0);
		end
	endtask

	task automatic runHand(input string name, input handCatE expCat);
		apbDataT data;
		apbWrite(name, `POKER_CTRL_ADDR, startWord, 1'b0);
		// done drops on the start edge, this read ends just before the result lands
		apbRead(name, `POKER_RESULT_ADDR, data, 1'b0);
		checkData($sformatf("%s done cleared", name), '0, data & doneMask);
		waitDone(name, data);
		checkCat(name, expCat, handCatE'(data[`POKER_CAT_W-1:0]));
		checkData($sformatf("%s spare bits", name), '0, data & ~(doneMask | catMask));
	endtask

	initial begin
		apbDataT data;
		apbDataT wdata;
		int waitCnt;
		apbReq = '0;
		void'($urandom(32'hcfd2c657));

		rows[0] = makeRow(2, 5, 7, 9, 12, 1'b0, catHighCard);
		// king wrapping to ace is no straight
		rows[1] = makeRow(13, 1, 2, 3, 4, 1'b0, catHighCard);
		rows[2] = makeRow(3, 3, 8, 10, 13, 1'b0, catOnePair);
		rows[3] = makeRow(4, 11, 9, 4, 9, 1'b0, catTwoPair);
		rows[4] = makeRow(7, 2, 7, 12, 7, 1'b0, catThree);
		// ace low and ace high straights
		rows[5] = makeRow(3, 1, 5, 2, 4, 1'b0, catStraight);
		rows[6] = makeRow(10, 11, 12, 13, 1, 1'b0, catStraight);
		rows[7] = makeRow(6, 8, 5, 9, 7, 1'b0, catStraight);
		rows[8] = makeRow(2, 6, 9, 11, 13, 1'b1, catFlush);
		rows[9] = makeRow(2, 2, 7, 9, 13, 1'b1, catFlush);
		// full house against a bare three
		rows[10] = makeRow(8, 12, 8, 12, 8, 1'b0, catFullHouse);
		rows[11] = makeRow(8, 12, 8, 3, 8, 1'b0, catThree);
		rows[12] = makeRow(5, 5, 10, 5, 5, 1'b0, catFour);
		rows[13] = makeRow(9, 9, 9, 9, 9, 1'b0, catFour);
		rows[14] = makeRow(1, 13, 12, 11, 10, 1'b1, catStraightFlush);
		rows[15] = makeRow(4, 5, 6, 7, 8, 1'b1, catStraightFlush);
		// ranks 0, 14 and 15 match but never join a straight
		rows[16] = makeRow(0, 1, 2, 3, 4, 1'b0, catHighCard);
		rows[17] = makeRow(14, 14, 3, 5, 7, 1'b0, catOnePair);
		rows[18] = makeRow(15, 10, 11, 12, 13, 1'b0, catHighCard);

		waitCnt = 0;
		while (rst !== 1'b0) begin
			waitCnt++;
			if (waitCnt >= resetLimit) begin
				$display("reset was never released");
				stopRun();
			end
			@(posedge clk);
		end

		// everything reads zero out of reset
		apbRead("reset result", `POKER_RESULT_ADDR, data, 1'b0);
		checkData("reset result", '0, data);
		for (int c = 0; c < numCards; c++) begin
			apbRead("reset card", cardAddr(c), data, 1'b0);
			checkData("reset card", '0, data);
		end

		// only the low six bits of a card stick
		for (int c = 0; c < numCards; c++) begin
			wdata = $urandom;
			apbWrite("card write", cardAddr(c), wdata, 1'b0);
			cardShadow[c] = wdata & cardMask;
		end
		for (int c = 0; c < numCards; c++) begin
			apbRead("card readback", cardAddr(c), data, 1'b0);
			checkData("card readback", cardShadow[c], data);
		end
		apbRead("ctrl read", `POKER_CTRL_ADDR, data, 1'b0);
		checkData("ctrl read", '0, data);

		for (int i = 0; i < numRows; i++) begin
			writeHand($sformatf("hand %0d", i), buildHand(rows[i], i));
			runHand($sformatf("hand %0d", i), rows[i].cat);
		end

		// holes in the map, the write next to ctrl must not start anything
		foreach (badAddr[k]) begin
			apbRead("unmapped read", badAddr[k], data, 1'b1);
			checkData("unmapped read", '0, data);
			apbWrite("unmapped write", badAddr[k], '1, 1'b1);
			// a stray start would still show done low on this read
			apbRead("done after unmapped", `POKER_RESULT_ADDR, data, 1'b0);
			checkData("done after unmapped", doneMask, data & doneMask);
		end
		for (int c = 0; c < numCards; c++) begin
			apbRead("card after unmapped", cardAddr(c), data, 1'b0);
			checkData("card after unmapped", cardShadow[c], data);
		end

		// second start overwrites the first result
		writeHand("first of two", buildHand(rows[12], 12));
		apbWrite("first of two", `POKER_CTRL_ADDR, startWord, 1'b0);
		writeHand("second of two", buildHand(rows[3], 3));
		runHand("second of two", rows[3].cat);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== poker.f ====
+incdir+rtl
rtl/pokerPkg.sv
rtl/handRegs.sv
rtl/cardMatcher.sv
rtl/straightDetector.sv
rtl/handClassifier.sv
rtl/pokerTop.sv
verif/clockGen.sv
verif/pokerTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the poker evaluator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f poker.f --top-module pokerTb -o pokerSim

# a $fatal in the testbench gives a non-zero exit status here
./obj_dir/pokerSim
